/* rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

`define XLEN      32  // data path width
`define REG_COUNT 32
`define REG_AW    5   // log2 of REG_COUNT

`endif

/* rv_core_pkg.sv */
package rv_core_pkg;

    // one instruction word, six encodings
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SR      = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;
    localparam logic [2:0] F3_LB      = 3'd0;
    localparam logic [2:0] F3_LH      = 3'd1;
    localparam logic [2:0] F3_LW      = 3'd2;
    localparam logic [2:0] F3_LBU     = 3'd4;
    localparam logic [2:0] F3_LHU     = 3'd5;
    localparam logic [2:0] F3_SB      = 3'd0;
    localparam logic [2:0] F3_SH      = 3'd1;
    localparam logic [2:0] F3_SW      = 3'd2;
    localparam logic [2:0] F3_BEQ     = 3'd0;
    localparam logic [2:0] F3_BNE     = 3'd1;
    localparam logic [2:0] F3_BLT     = 3'd4;
    localparam logic [2:0] F3_BGE     = 3'd5;
    localparam logic [2:0] F3_BLTU    = 3'd6;
    localparam logic [2:0] F3_BGEU    = 3'd7;
    localparam logic [2:0] F3_JALR    = 3'd0;
    localparam logic [2:0] F3_CSRRW   = 3'd1;
    localparam logic [2:0] F3_CSRRS   = 3'd2;
    localparam logic [2:0] F3_CSRRC   = 3'd3;
    localparam logic [2:0] F3_CSRRWI  = 3'd5;
    localparam logic [2:0] F3_CSRRSI  = 3'd6;
    localparam logic [2:0] F3_CSRRCI  = 3'd7;

    localparam logic [31:0] INST_ECALL = 32'h0000_0073;

    typedef enum logic [4:0] {
        ALU_X, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR, ALU_COPY1,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } exe_fun_e;

    typedef enum logic [3:0] {OP1_X, OP1_RS1, OP1_PC, OP1_IMZ} op1_sel_e;
    typedef enum logic [3:0] {OP2_X, OP2_RS2W, OP2_IMI, OP2_IMS, OP2_IMJ, OP2_IMU} op2_sel_e;
    typedef enum logic [4:0] {MEN_X, MEN_SB, MEN_SH, MEN_SW} mem_wen_e;

    typedef enum logic [3:0] {
        WB_X, WB_ALU, WB_PC, WB_CSR,
        WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW
    } wb_sel_e;

    typedef enum logic [2:0] {CSR_X, CSR_W, CSR_S, CSR_C, CSR_E} csr_cmd_e;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    input  logic               wr_en,
    input  logic [`REG_AW-1:0] wr_addr,
    input  logic [`XLEN-1:0]   wr_data,
    output logic [`XLEN-1:0]   rs1_rdata,
    output logic [`XLEN-1:0]   rs2_rdata
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    function automatic logic [`XLEN-1:0] rd_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && wr_addr == addr) begin
            return wr_data;  // write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_rdata = rd_port(rs1_addr);
        rs2_rdata = rd_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // x0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* rv_decode_stage.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_decode_stage import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1_rdata,
    input  logic [`XLEN-1:0]   rs2_rdata,
    output logic [`REG_AW-1:0] rs1_addr,
    output logic [`REG_AW-1:0] rs2_addr,
    output logic [`XLEN-1:0]   pc_q,
    output logic [`XLEN-1:0]   imm_b,
    output logic [`XLEN-1:0]   op1_data,
    output logic [`XLEN-1:0]   op2_data,
    output logic [`XLEN-1:0]   rs2_data,
    output exe_fun_e           exe_fun,
    output mem_wen_e           mem_wen,
    output logic               rf_wen,
    output wb_sel_e            wb_sel,
    output logic [`REG_AW-1:0] wb_addr,
    output csr_cmd_e           csr_cmd,
    output logic               jmp_flg
);

    rv_inst_u         ins;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b_d, imm_j, imm_u, imm_z;
    logic [`XLEN-1:0] op1_d, op2_d;
    logic             is_op, f7_ok, legal;
    exe_fun_e         exe_fun_d;
    op1_sel_e         op1_sel;
    op2_sel_e         op2_sel;
    mem_wen_e         mem_wen_d;
    logic             rf_wen_d, jmp_d;
    wb_sel_e          wb_sel_d;
    csr_cmd_e         csr_cmd_d;

    assign ins      = inst;
    assign rs1_addr = ins.r.rs1;
    assign rs2_addr = ins.r.rs2;

    assign imm_i   = {{20{ins.i.imm11_0[11]}}, ins.i.imm11_0};
    assign imm_s   = {{20{ins.s.imm11_5[6]}}, ins.s.imm11_5, ins.s.imm4_0};
    assign imm_b_d = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                      ins.b.imm4_1, 1'b0};
    assign imm_j   = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                      ins.j.imm10_1, 1'b0};
    assign imm_u   = {ins.u.imm31_12, 12'd0};
    assign imm_z   = {{(`XLEN-5){1'b0}}, ins.r.rs1};  // csr immediate sits in rs1

    // funct7 is base, or alt for sra/srai/sub
    assign is_op = (ins.r.opcode == OPC_OP);
    assign f7_ok = (ins.r.funct7 == F7_BASE) ||
                   (ins.r.funct7 == F7_ALT &&
                    (ins.r.funct3 == F3_SR || (is_op && ins.r.funct3 == F3_ADD_SUB)));

    always_comb begin
        exe_fun_d = ALU_X;
        op1_sel   = OP1_X;
        op2_sel   = OP2_X;
        mem_wen_d = MEN_X;
        rf_wen_d  = 1'b0;
        wb_sel_d  = WB_X;
        csr_cmd_d = CSR_X;
        jmp_d     = 1'b0;
        legal     = 1'b1;
        case (ins.r.opcode)
            OPC_LOAD: begin
                exe_fun_d = ALU_ADD;
                op1_sel   = OP1_RS1;
                op2_sel   = OP2_IMI;
                rf_wen_d  = 1'b1;
                case (ins.i.funct3)
                    F3_LB:   wb_sel_d = WB_MEMB;
                    F3_LH:   wb_sel_d = WB_MEMH;
                    F3_LW:   wb_sel_d = WB_MEMW;
                    F3_LBU:  wb_sel_d = WB_MEMBU;
                    F3_LHU:  wb_sel_d = WB_MEMHU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                exe_fun_d = ALU_ADD;
                op1_sel   = OP1_RS1;
                op2_sel   = OP2_IMS;
                case (ins.s.funct3)
                    F3_SB:   mem_wen_d = MEN_SB;
                    F3_SH:   mem_wen_d = MEN_SH;
                    F3_SW:   mem_wen_d = MEN_SW;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP, OPC_OP_IMM: begin
                op1_sel  = OP1_RS1;
                op2_sel  = is_op ? OP2_RS2W : OP2_IMI;
                rf_wen_d = 1'b1;
                wb_sel_d = WB_ALU;
                case (ins.r.funct3)
                    F3_ADD_SUB: exe_fun_d = (is_op && ins.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     exe_fun_d = ALU_SLL;
                    F3_SLT:     exe_fun_d = ALU_SLT;
                    F3_SLTU:    exe_fun_d = ALU_SLTU;
                    F3_XOR:     exe_fun_d = ALU_XOR;
                    F3_SR:      exe_fun_d = (ins.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      exe_fun_d = ALU_OR;
                    F3_AND:     exe_fun_d = ALU_AND;
                    default:    legal = 1'b0;
                endcase
                if (!f7_ok && (is_op || ins.r.funct3 == F3_SLL || ins.r.funct3 == F3_SR)) begin
                    legal = 1'b0;  // immediate ops only check funct7 on shifts
                end
            end
            OPC_BRANCH: begin
                op1_sel = OP1_RS1;
                op2_sel = OP2_RS2W;
                case (ins.b.funct3)
                    F3_BEQ:  exe_fun_d = BR_BEQ;
                    F3_BNE:  exe_fun_d = BR_BNE;
                    F3_BLT:  exe_fun_d = BR_BLT;
                    F3_BGE:  exe_fun_d = BR_BGE;
                    F3_BLTU: exe_fun_d = BR_BLTU;
                    F3_BGEU: exe_fun_d = BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                exe_fun_d = ALU_ADD;
                op1_sel   = OP1_PC;
                op2_sel   = OP2_IMJ;
                rf_wen_d  = 1'b1;
                wb_sel_d  = WB_PC;
                jmp_d     = 1'b1;
            end
            OPC_JALR: begin
                exe_fun_d = ALU_JALR;
                op1_sel   = OP1_RS1;
                op2_sel   = OP2_IMI;
                rf_wen_d  = 1'b1;
                wb_sel_d  = WB_PC;
                jmp_d     = 1'b1;
                legal     = (ins.i.funct3 == F3_JALR);
            end
            OPC_LUI, OPC_AUIPC: begin
                exe_fun_d = ALU_ADD;
                op1_sel   = (ins.u.opcode == OPC_AUIPC) ? OP1_PC : OP1_X;
                op2_sel   = OP2_IMU;
                rf_wen_d  = 1'b1;
                wb_sel_d  = WB_ALU;
            end
            OPC_SYSTEM: begin
                if (ins.raw == INST_ECALL) begin
                    csr_cmd_d = CSR_E;
                end else begin
                    exe_fun_d = ALU_COPY1;
                    op1_sel   = ins.i.funct3[2] ? OP1_IMZ : OP1_RS1;
                    rf_wen_d  = 1'b1;
                    wb_sel_d  = WB_CSR;
                    case (ins.i.funct3)
                        F3_CSRRW, F3_CSRRWI: csr_cmd_d = CSR_W;
                        F3_CSRRS, F3_CSRRSI: csr_cmd_d = CSR_S;
                        F3_CSRRC, F3_CSRRCI: csr_cmd_d = CSR_C;
                        default:             legal = 1'b0;
                    endcase
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin  // unmatched word acts as a bubble
            exe_fun_d = ALU_X;
            op1_sel   = OP1_X;
            op2_sel   = OP2_X;
            mem_wen_d = MEN_X;
            rf_wen_d  = 1'b0;
            wb_sel_d  = WB_X;
            csr_cmd_d = CSR_X;
            jmp_d     = 1'b0;
        end
    end

    always_comb begin
        case (op1_sel)
            OP1_RS1: op1_d = rs1_rdata;
            OP1_PC:  op1_d = pc;
            OP1_IMZ: op1_d = imm_z;
            default: op1_d = '0;
        endcase
        case (op2_sel)
            OP2_RS2W: op2_d = rs2_rdata;
            OP2_IMI:  op2_d = imm_i;
            OP2_IMS:  op2_d = imm_s;
            OP2_IMJ:  op2_d = imm_j;
            OP2_IMU:  op2_d = imm_u;
            default:  op2_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_fun <= ALU_X;
            mem_wen <= MEN_X;
            rf_wen  <= 1'b0;
            wb_sel  <= WB_X;
            csr_cmd <= CSR_X;
            jmp_flg <= 1'b0;
        end else begin
            exe_fun <= exe_fun_d;
            mem_wen <= mem_wen_d;
            rf_wen  <= rf_wen_d;
            wb_sel  <= wb_sel_d;
            csr_cmd <= csr_cmd_d;
            jmp_flg <= jmp_d;
        end
    end

    always_ff @(posedge clk) begin
        pc_q     <= pc;
        imm_b    <= imm_b_d;
        op1_data <= op1_d;
        op2_data <= op2_d;
        rs2_data <= rs2_rdata;
        wb_addr  <= ins.r.rd;
    end

endmodule

/* rv_execute_stage.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_execute_stage import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   pc_q,
    input  logic [`XLEN-1:0]   imm_b,
    input  logic [`XLEN-1:0]   op1_data,
    input  logic [`XLEN-1:0]   op2_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  exe_fun_e           exe_fun,
    input  logic               rf_wen,
    input  wb_sel_e            wb_sel,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic               jmp_flg,
    input  mem_wen_e           mem_wen,
    input  csr_cmd_e           csr_cmd,
    output logic [`XLEN-1:0]   alu_out,
    output logic               br_flg,
    output logic [`XLEN-1:0]   br_target,
    output logic               jmp_flg_q,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_addr_q,
    output logic [`XLEN-1:0]   wb_data,
    output mem_wen_e           mem_wen_q,
    output csr_cmd_e           csr_cmd_q,
    output wb_sel_e            wb_sel_q
);

    logic [`XLEN-1:0] sum, alu_d, wb_data_d;
    logic [4:0]       shamt;
    logic             br_d, wb_en_d;

    assign sum   = op1_data + op2_data;
    assign shamt = op2_data[4:0];

    always_comb begin
        case (exe_fun)
            ALU_ADD:   alu_d = sum;
            ALU_SUB:   alu_d = op1_data - op2_data;
            ALU_AND:   alu_d = op1_data & op2_data;
            ALU_OR:    alu_d = op1_data | op2_data;
            ALU_XOR:   alu_d = op1_data ^ op2_data;
            ALU_SLL:   alu_d = op1_data << shamt;
            ALU_SRL:   alu_d = op1_data >> shamt;
            ALU_SRA:   alu_d = $signed(op1_data) >>> shamt;
            ALU_SLT:   alu_d = {{(`XLEN-1){1'b0}}, $signed(op1_data) < $signed(op2_data)};
            ALU_SLTU:  alu_d = {{(`XLEN-1){1'b0}}, op1_data < op2_data};
            ALU_JALR:  alu_d = {sum[`XLEN-1:1], 1'b0};
            ALU_COPY1: alu_d = op1_data;
            default:   alu_d = '0;
        endcase
        case (exe_fun)
            BR_BEQ:  br_d = (op1_data == op2_data);
            BR_BNE:  br_d = (op1_data != op2_data);
            BR_BLT:  br_d = ($signed(op1_data) < $signed(op2_data));
            BR_BGE:  br_d = ($signed(op1_data) >= $signed(op2_data));
            BR_BLTU: br_d = (op1_data < op2_data);
            BR_BGEU: br_d = (op1_data >= op2_data);
            default: br_d = 1'b0;
        endcase
    end

    assign wb_data_d = (wb_sel == WB_PC) ? pc_q + `XLEN'd4 : alu_d;  // link value
    assign wb_en_d   = rf_wen && (wb_sel == WB_ALU || wb_sel == WB_PC);

    always_ff @(posedge clk) begin
        if (rst) begin
            br_flg    <= 1'b0;
            jmp_flg_q <= 1'b0;
            wb_en     <= 1'b0;
            mem_wen_q <= MEN_X;
            csr_cmd_q <= CSR_X;
            wb_sel_q  <= WB_X;
        end else begin
            br_flg    <= br_d;
            jmp_flg_q <= jmp_flg;
            wb_en     <= wb_en_d;
            mem_wen_q <= mem_wen;
            csr_cmd_q <= csr_cmd;
            wb_sel_q  <= wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        alu_out   <= alu_d;
        br_target <= pc_q + imm_b;
        wb_addr_q <= wb_addr;
        wb_data   <= (mem_wen != MEN_X) ? rs2_data : wb_data_d;  // store data, no memory here
    end

endmodule

/* rv_decode_exec.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_decode_exec import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   pc,
    output logic [`XLEN-1:0]   alu_out,
    output logic               br_flg,
    output logic [`XLEN-1:0]   br_target,
    output logic               jmp_flg,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_addr,
    output logic [`XLEN-1:0]   wb_data,
    output mem_wen_e           mem_wen,
    output csr_cmd_e           csr_cmd,
    output wb_sel_e            wb_sel
);

    logic [`REG_AW-1:0] rs1_addr, rs2_addr, de_wb_addr;
    logic [`XLEN-1:0]   rs1_rdata, rs2_rdata;
    logic [`XLEN-1:0]   de_pc, de_imm_b, de_op1, de_op2, de_rs2;
    exe_fun_e           de_exe_fun;
    mem_wen_e           de_mem_wen;
    wb_sel_e            de_wb_sel;
    csr_cmd_e           de_csr_cmd;
    logic               de_rf_wen, de_jmp_flg;

    rv_regfile regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wr_en     (wb_en),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    rv_decode_stage decode_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .pc        (pc),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .pc_q      (de_pc),
        .imm_b     (de_imm_b),
        .op1_data  (de_op1),
        .op2_data  (de_op2),
        .rs2_data  (de_rs2),
        .exe_fun   (de_exe_fun),
        .mem_wen   (de_mem_wen),
        .rf_wen    (de_rf_wen),
        .wb_sel    (de_wb_sel),
        .wb_addr   (de_wb_addr),
        .csr_cmd   (de_csr_cmd),
        .jmp_flg   (de_jmp_flg)
    );

    rv_execute_stage execute_i (
        .clk       (clk),
        .rst       (rst),
        .pc_q      (de_pc),
        .imm_b     (de_imm_b),
        .op1_data  (de_op1),
        .op2_data  (de_op2),
        .rs2_data  (de_rs2),
        .exe_fun   (de_exe_fun),
        .rf_wen    (de_rf_wen),
        .wb_sel    (de_wb_sel),
        .wb_addr   (de_wb_addr),
        .jmp_flg   (de_jmp_flg),
        .mem_wen   (de_mem_wen),
        .csr_cmd   (de_csr_cmd),
        .alu_out   (alu_out),
        .br_flg    (br_flg),
        .br_target (br_target),
        .jmp_flg_q (jmp_flg),
        .wb_en     (wb_en),
        .wb_addr_q (wb_addr),
        .wb_data   (wb_data),
        .mem_wen_q (mem_wen),
        .csr_cmd_q (csr_cmd),
        .wb_sel_q  (wb_sel)
    );

endmodule

/* rv_decode_exec_props.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_decode_exec_props import rv_core_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               wb_en,
    input logic [`REG_AW-1:0] wb_addr,
    input logic [`REG_AW-1:0] rs1_addr,
    input logic [`XLEN-1:0]   rs1_rdata,
    input logic               br_flg,
    input logic               jmp_flg,
    input mem_wen_e           mem_wen,
    input csr_cmd_e           csr_cmd,
    input wb_sel_e            wb_sel
);

    // x0 reads zero even while a write to x0 is in flight
    x0_write_ignored: assert property (@(posedge clk) disable iff (rst)
        (wb_en && wb_addr == '0 && rs1_addr == '0) |-> (rs1_rdata == '0))
        else $error("write to x0 became visible on the read port");

    branch_jump_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(br_flg && jmp_flg))
        else $error("branch and jump flags high together");

    controls_clear_after_reset: assert property (@(posedge clk)
        rst |=> (!wb_en && !br_flg && !jmp_flg &&
                 mem_wen == MEN_X && csr_cmd == CSR_X && wb_sel == WB_X))
        else $error("control outputs not cleared by reset");

endmodule

bind rv_decode_exec rv_decode_exec_props props_i (
    .clk       (clk),
    .rst       (rst),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .rs1_addr  (rs1_addr),
    .rs1_rdata (rs1_rdata),
    .br_flg    (br_flg),
    .jmp_flg   (jmp_flg),
    .mem_wen   (mem_wen),
    .csr_cmd   (csr_cmd),
    .wb_sel    (wb_sel)
);

/* rv_decode_exec_tb.sv */
`timescale 1ns/1ns
`include "rv_core_config.svh"

module rv_decode_exec_tb import rv_core_pkg::*; ();

    localparam int    NFIELD     = 10;
    localparam string TRACE_FILE = "rv_decode_exec_trace.txt";

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   inst;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   alu_out;
    logic               br_flg;
    logic [`XLEN-1:0]   br_target;
    logic               jmp_flg;
    logic               wb_en;
    logic [`REG_AW-1:0] wb_addr;
    logic [`XLEN-1:0]   wb_data;
    mem_wen_e           mem_wen;
    csr_cmd_e           csr_cmd;
    wb_sel_e            wb_sel;

    // one entry per trace line, expected fields flattened NFIELD per line
    string       name_q[$];
    logic [31:0] inst_q[$];
    logic [31:0] pc_val_q[$];
    logic [31:0] exp_q[$];
    bit          care_q[$];

    string field_names[NFIELD] = '{"alu_out", "br_flg", "br_target", "jmp_flg", "wb_en",
                                   "wb_addr", "wb_data", "mem_wen", "csr_cmd", "wb_sel"};

    int cycles      = 0;
    int cycle_limit = 1000000;  // replaced once the trace length is known

    rv_decode_exec dut_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .pc        (pc),
        .alu_out   (alu_out),
        .br_flg    (br_flg),
        .br_target (br_target),
        .jmp_flg   (jmp_flg),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .mem_wen   (mem_wen),
        .csr_cmd   (csr_cmd),
        .wb_sel    (wb_sel)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] hex_value(input string s);
        logic [31:0] v;
        v = '0;
        void'($sscanf(s, "%h", v));
        return v;
    endfunction

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        string name;
        string tok[12];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            $display("Regression failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // comment or blank
            end
            n = $sscanf(line, "%s %s %s %s %s %s %s %s %s %s %s %s %s", name,
                        tok[0], tok[1], tok[2], tok[3], tok[4], tok[5],
                        tok[6], tok[7], tok[8], tok[9], tok[10], tok[11]);
            if (n != 13) begin
                $display("trace line has %0d columns instead of 13: %s", n, line);
                $display("Regression failed");
                $fatal(1);
            end
            name_q.push_back(name);
            inst_q.push_back(hex_value(tok[0]));
            pc_val_q.push_back(hex_value(tok[1]));
            for (int f = 0; f < NFIELD; f++) begin
                care_q.push_back(tok[f+2] != "-");  // dash means not checked
                exp_q.push_back(tok[f+2] == "-" ? 32'h0 : hex_value(tok[f+2]));
            end
        end
        $fclose(fd);
    endtask

    task automatic check_row(input int k);
        logic [31:0] act[NFIELD];
        logic [31:0] exp;
        act[0] = alu_out;
        act[1] = 32'(br_flg);
        act[2] = br_target;
        act[3] = 32'(jmp_flg);
        act[4] = 32'(wb_en);
        act[5] = 32'(wb_addr);
        act[6] = wb_data;
        act[7] = 32'(mem_wen);
        act[8] = 32'(csr_cmd);
        act[9] = 32'(wb_sel);
        for (int f = 0; f < NFIELD; f++) begin
            exp = exp_q[k*NFIELD+f];
            if (care_q[k*NFIELD+f]) begin
                assert (act[f] == exp) else begin
                    $display("mismatch %s %s expected %h actual %h",
                             name_q[k], field_names[f], exp, act[f]);
                    $display("Regression failed");
                    $fatal(1);
                end
            end
        end
    endtask

    initial begin
        int n;
        clk  = 1'b0;
        rst  = 1'b1;
        inst = '0;
        pc   = '0;
        load_trace();
        n           = name_q.size();
        cycle_limit = n + 20;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        // results of line k show up two edges after it is driven
        for (int k = 0; k < n + 2; k++) begin
            @(posedge clk);
            #1;
            if (k >= 2) begin
                check_row(k - 2);
            end
            if (k < n) begin
                inst = inst_q[k];
                pc   = pc_val_q[k];
            end else begin
                inst = '0;
                pc   = '0;
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* rv_decode_exec_trace.txt */
# name inst pc | expected 2 cycles later: alu_out br_flg br_target jmp_flg wb_en
# wb_addr wb_data mem_wen csr_cmd wb_sel (hex, a dash is not checked)
nop0 00000000 00000000 0 0 00000000 0 0 0 0 0 0 0
nop1 00000000 00000004 0 0 00000004 0 0 0 0 0 0 0
addi_x1 00500093 00000008 00000005 0 - 0 1 01 00000005 0 0 1
addi_x2 FFD00113 0000000C FFFFFFFD 0 - 0 1 02 FFFFFFFD 0 0 1
lui_x5 800002B7 00000010 80000000 0 - 0 1 05 80000000 0 0 1
add_x3 002081B3 00000014 00000002 0 - 0 1 03 00000002 0 0 1
sub_x4 40208233 00000018 00000008 0 - 0 1 04 00000008 0 0 1
and_x6 0020F333 0000001C 00000005 0 - 0 1 06 00000005 0 0 1
or_x7 0020E3B3 00000020 FFFFFFFD 0 - 0 1 07 FFFFFFFD 0 0 1
xor_x8 0020C433 00000024 FFFFFFF8 0 - 0 1 08 FFFFFFF8 0 0 1
sll_x9 001114B3 00000028 FFFFFFA0 0 - 0 1 09 FFFFFFA0 0 0 1
srl_x10 00115533 0000002C 07FFFFFF 0 - 0 1 0A 07FFFFFF 0 0 1
sra_x11 401155B3 00000030 FFFFFFFF 0 - 0 1 0B FFFFFFFF 0 0 1
slt_x12 00112633 00000034 00000001 0 - 0 1 0C 00000001 0 0 1
sltu_x13 001136B3 00000038 00000000 0 - 0 1 0D 00000000 0 0 1
srai_x14 4042D713 0000003C F8000000 0 - 0 1 0E F8000000 0 0 1
auipc_x15 12345797 00000040 12345040 0 - 0 1 0F 12345040 0 0 1
slti_x16 FFF12813 00000044 00000001 0 - 0 1 10 00000001 0 0 1
beq_taken 00608863 00000048 0 1 00000058 0 0 - - 0 0 0
beq_not FE208CE3 0000004C 0 0 00000044 0 0 - - 0 0 0
bne_taken 00209863 00000050 0 1 00000060 0 0 - - 0 0 0
bne_not FE609CE3 00000054 0 0 0000004C 0 0 - - 0 0 0
blt_taken 00114863 00000058 0 1 00000068 0 0 - - 0 0 0
blt_not FE20CCE3 0000005C 0 0 00000054 0 0 - - 0 0 0
bge_taken 0020D863 00000060 0 1 00000070 0 0 - - 0 0 0
bge_not FE115CE3 00000064 0 0 0000005C 0 0 - - 0 0 0
bltu_taken 0020E863 00000068 0 1 00000078 0 0 - - 0 0 0
bltu_not FE116CE3 0000006C 0 0 00000064 0 0 - - 0 0 0
bgeu_taken 00117863 00000070 0 1 00000080 0 0 - - 0 0 0
bgeu_not FE20FCE3 00000074 0 0 0000006C 0 0 - - 0 0 0
jal_x17 100008EF 00000078 00000178 0 - 1 1 11 0000007C 0 0 2
jalr_x18 00608967 0000007C 0000000A 0 - 1 1 12 00000080 0 0 2
addi_x0 00900013 00000080 00000009 0 - 0 1 00 00000009 0 0 1
lw_x20 0040AA03 00000084 00000009 0 - 0 0 14 00000009 0 0 8
or_x19_x0 001069B3 00000088 00000005 0 - 0 1 13 00000005 0 0 1
lbu_x21 FFF14A83 0000008C FFFFFFFC 0 - 0 0 15 FFFFFFFC 0 0 5
sw_x1 00112423 00000090 00000005 0 - 0 0 - 00000005 3 0 0
sb_x2 FE208E23 00000094 00000001 0 - 0 0 - FFFFFFFD 1 0 0
csrrw_x22 30009B73 00000098 00000005 0 - 0 0 16 00000005 0 1 3
csrrsi_x23 300D6BF3 0000009C 0000001A 0 - 0 0 17 0000001A 0 2 3
csrrc_x24 30013C73 000000A0 FFFFFFFD 0 - 0 0 18 FFFFFFFD 0 3 3
ecall 00000073 000000A4 0 0 000000A4 0 0 00 0 0 4 0
nop_end 00000000 000000A8 0 0 000000A8 0 0 0 0 0 0 0
or_x25_x20 000A6CB3 000000AC 00000000 0 - 0 1 19 00000000 0 0 1

/* rv_decode_exec.f */
+incdir+.
rv_core_pkg.sv
rv_regfile.sv
rv_decode_stage.sv
rv_execute_stage.sv
rv_decode_exec.sv
rv_decode_exec_props.sv
rv_decode_exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       := rv_decode_exec_tb
FILELIST  := rv_decode_exec.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
